/* compile.f */
+incdir+include
rtl/tl45_bus_pkg.sv
rtl/wb_pri_arbiter.sv
rtl/bus_decoder.sv
rtl/sys_info_dev.sv
rtl/word_mem.sv
rtl/switch_led_dev.sv
rtl/tl45_bus_top.sv
tests/tb_tl45_bus.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tl45_bus
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)

/* include/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int PORT_D   = 0;
localparam int PORT_I   = 1;
localparam int PORT_DBG = 2;

localparam int RESP_NONE = 0;
localparam int RESP_ACK  = 1;
localparam int RESP_ERR  = 2;

localparam int STALL_LIMIT = 64;
localparam int RESP_LIMIT  = 8;

// address map as seen from the requesters
localparam logic [29:0] SYS_BASE   = 30'h0020_0000;
localparam logic [29:0] SWLED_WORD = 30'h0040_0001;
localparam logic [31:0] ID_EXPECT  = 32'h2019_1028;

function automatic string port_name(input int port);
    case (port)
        PORT_D:  return "dport";
        PORT_I:  return "iport";
        default: return "dbg";
    endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] expected);
    if (got !== expected) begin
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
        error_count++;
    end
endtask

task automatic report_failure(input string msg);
    $display("error: %s", msg);
    error_count++;
endtask

task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, error_count - errs_before);
    end
endtask

task automatic drive_port(input int port, input logic cyc, input logic stb, input logic we,
        input logic [29:0] addr, input logic [31:0] data, input logic [3:0] sel);
    req_cyc[port]  = cyc;
    req_stb[port]  = stb;
    req_we[port]   = we;
    req_addr[port] = addr;
    req_data[port] = data;
    req_sel[port]  = sel;
endtask

// one transfer on one port, latency counted in falling edges after the issuing edge
task automatic bus_access(input int port, input logic we, input logic [29:0] addr,
        input logic [31:0] wdata, input logic [3:0] sel, input logic keep_cyc,
        output logic [31:0] rdata, output int resp, output int latency,
        output int stalls);
    resp    = RESP_NONE;
    rdata   = '0;
    latency = 0;
    stalls  = 0;
    @(negedge clk);
    drive_port(port, 1'b1, 1'b1, we, addr, wdata, sel);
    // stall is combinational, look once the inputs have settled
    #(CLK_PERIOD / 4);
    while (resp_stall[port] && stalls < STALL_LIMIT) begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        stalls++;
    end
    if (resp_stall[port]) begin
        report_failure({"the ", port_name(port), " port was never granted the bus"});
        req_stb[port] = 1'b0;
        req_cyc[port] = 1'b0;
    end else begin
        // next rising edge issues the transfer
        @(negedge clk);
        latency = 1;
        req_stb[port] = 1'b0;
        while (!resp_ack[port] && !resp_err[port] && latency < RESP_LIMIT) begin
            @(negedge clk);
            latency++;
        end
        if (resp_ack[port]) begin
            resp = RESP_ACK;
        end else if (resp_err[port]) begin
            resp = RESP_ERR;
        end else begin
            report_failure({"the ", port_name(port), " port got neither ack nor err"});
        end
        rdata = rd_data;
        if (!keep_cyc || resp == RESP_NONE) begin
            req_cyc[port] = 1'b0;
        end
    end
endtask

task automatic check_response(input int port, input int resp, input int latency,
        input int exp_resp, input int exp_latency);
    string sig;
    if (exp_resp == RESP_ERR) begin
        sig = {"o_", port_name(port), "_err"};
    end else begin
        sig = {"o_", port_name(port), "_ack"};
    end
    if (resp != RESP_NONE) begin
        check_value({sig, " response"}, 32'(resp), 32'(exp_resp));
        check_value({sig, " latency"}, 32'(latency), 32'(exp_latency));
    end
endtask

task automatic test_reset_and_memory();
    int          errs_before;
    int          resp;
    int          lat;
    int          stalls;
    logic [31:0] wdata;
    logic [31:0] patch;
    logic [31:0] rdata;
    logic [29:0] addr;
    errs_before = error_count;
    check_value("o_leds", 32'(leds), 32'h0);
    check_value("o_sys_int", 32'(sys_int), 32'h0);
    check_value("o_*_ack", 32'(resp_ack), 32'h0);
    check_value("o_*_err", 32'(resp_err), 32'h0);
    for (int p = 0; p < 3; p++) begin
        addr  = 30'h0000_0100 + 30'(p);
        wdata = $urandom;
        bus_access(p, 1'b1, addr, wdata, 4'hf, 1'b0, rdata, resp, lat, stalls);
        check_response(p, resp, lat, RESP_ACK, 2);
        bus_access(p, 1'b0, addr, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
        check_response(p, resp, lat, RESP_ACK, 2);
        check_value({"o_rd_data via ", port_name(p)}, rdata, wdata);
    end
    // only the two middle bytes change
    addr  = 30'h0000_0200;
    wdata = $urandom;
    patch = $urandom;
    bus_access(PORT_D, 1'b1, addr, wdata, 4'hf, 1'b0, rdata, resp, lat, stalls);
    bus_access(PORT_D, 1'b1, addr, patch, 4'b0110, 1'b0, rdata, resp, lat, stalls);
    check_response(PORT_D, resp, lat, RESP_ACK, 2);
    bus_access(PORT_D, 1'b0, addr, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_value("o_rd_data after byte write", rdata,
        {wdata[31:24], patch[23:8], wdata[7:0]});
    finish_test("reset and memory", errs_before);
endtask

task automatic test_sys_device();
    int          errs_before;
    int          resp;
    int          lat;
    int          stalls;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] count0;
    errs_before = error_count;
    bus_access(PORT_I, 1'b0, SYS_BASE, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_response(PORT_I, resp, lat, RESP_ACK, 2);
    check_value("o_rd_data identifier", rdata, ID_EXPECT);
    wdata = $urandom;
    bus_access(PORT_DBG, 1'b1, SYS_BASE + 30'd1, wdata, 4'hf, 1'b0, rdata, resp, lat, stalls);
    bus_access(PORT_D, 1'b0, SYS_BASE + 30'd1, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_value("o_rd_data scratch", rdata, wdata);
    bus_access(PORT_D, 1'b1, SYS_BASE + 30'd4, 32'h1, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_value("o_sys_int after set", 32'(sys_int), 32'h1);
    bus_access(PORT_D, 1'b1, SYS_BASE + 30'd4, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_value("o_sys_int after clear", 32'(sys_int), 32'h0);
    bus_access(PORT_D, 1'b0, SYS_BASE + 30'd3, 32'h0, 4'hf, 1'b0, count0, resp, lat, stalls);
    repeat (20) @(negedge clk);
    bus_access(PORT_D, 1'b0, SYS_BASE + 30'd3, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_value("o_rd_data power counter increases", 32'(rdata > count0), 32'h1);
    finish_test("system device", errs_before);
endtask

task automatic test_bus_error();
    int          errs_before;
    int          resp;
    int          lat;
    int          stalls;
    int          p;
    logic [31:0] rdata;
    logic [29:0] bad_addr [2];
    errs_before = error_count;
    bad_addr[0] = 30'h0123_4567;
    bad_addr[1] = 30'h0040_0002;
    for (int k = 0; k < 2; k++) begin
        p = (k == 0) ? PORT_D : PORT_DBG;
        bus_access(p, 1'b0, bad_addr[k], 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
        check_response(p, resp, lat, RESP_ERR, 1);
        // an errored access must not also be acked later
        repeat (3) begin
            @(negedge clk);
            check_value({"o_*_ack after ", port_name(p), " err"}, 32'(resp_ack), 32'h0);
        end
        bus_access(PORT_I, 1'b0, SYS_BASE + 30'd2, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
        check_value("o_rd_data bus error address", rdata, {bad_addr[k], 2'b00});
    end
    finish_test("bus error", errs_before);
endtask

task automatic test_switch_led();
    int          errs_before;
    int          resp;
    int          lat;
    int          stalls;
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic [15:0] led_val;
    errs_before = error_count;
    rnd     = $urandom;
    led_val = rnd[15:0];
    bus_access(PORT_D, 1'b1, SWLED_WORD, {16'h0, led_val}, 4'b0011, 1'b0,
        rdata, resp, lat, stalls);
    check_response(PORT_D, resp, lat, RESP_ACK, 2);
    check_value("o_leds", 32'(leds), 32'(led_val));
    // a single byte select leaves the leds alone
    bus_access(PORT_D, 1'b1, SWLED_WORD, ~rnd, 4'b0001, 1'b0, rdata, resp, lat, stalls);
    check_value("o_leds after partial write", 32'(leds), 32'(led_val));
    rnd = $urandom;
    @(negedge clk);
    switches = rnd[15:0];
    bus_access(PORT_I, 1'b0, SWLED_WORD, 32'h0, 4'hf, 1'b0, rdata, resp, lat, stalls);
    check_response(PORT_I, resp, lat, RESP_ACK, 2);
    check_value("o_rd_data leds and switches", rdata, {led_val, rnd[15:0]});
    finish_test("switch and led", errs_before);
endtask

task automatic test_arbitration();
    int          errs_before;
    int          wport;
    int          dresp;
    int          dlat;
    int          dstalls;
    int          oresp;
    int          olat;
    int          ostalls;
    logic [31:0] drd;
    logic [31:0] ord;
    logic [31:0] words [3];
    logic [29:0] addr;
    time         d_release;
    time         o_done;
    errs_before = error_count;
    for (int round = 0; round < 2; round++) begin
        // round 0 pits iport against dport, round 1 the debug port
        wport = (round == 0) ? PORT_I : PORT_DBG;
        addr  = 30'h0000_0300 + 30'(round);
        for (int k = 0; k < 3; k++) begin
            words[k] = $urandom;
        end
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    bus_access(PORT_D, 1'b1, addr, words[k], 4'hf, 1'b1,
                        drd, dresp, dlat, dstalls);
                    check_response(PORT_D, dresp, dlat, RESP_ACK, 2);
                    check_value("o_dport_stall cycles", 32'(dstalls), 32'h0);
                end
                req_cyc[PORT_D] = 1'b0;
                d_release = $time;
            end
            begin
                bus_access(wport, 1'b0, addr, 32'h0, 4'hf,
                    1'b0, ord, oresp, olat, ostalls);
                o_done = $time;
            end
        join
        check_response(wport, oresp, olat, RESP_ACK, 2);
        check_value({"o_", port_name(wport), "_stall seen"}, 32'(ostalls > 0), 32'h1);
        check_value({"o_", port_name(wport), "_ack after release"},
            32'(o_done > d_release), 32'h1);
        check_value("o_rd_data of waiting port", ord, words[2]);
    end
    finish_test("arbitration", errs_before);
endtask

`endif

/* tests/tb_tl45_bus.sv */
`timescale 1ns/1ps

module tb_tl45_bus;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 97852;

    // upper bound of one test in cycles, the longest needs well under this
    localparam int TEST_COUNT  = 5;
    localparam int TEST_CYCLES = 300;
    localparam int MARGIN      = 2;

    logic        clk;
    logic        reset;

    // requester signals, indexed by port number
    logic [2:0]  req_cyc;
    logic [2:0]  req_stb;
    logic [2:0]  req_we;
    logic [29:0] req_addr [3];
    logic [31:0] req_data [3];
    logic [3:0]  req_sel  [3];
    logic [2:0]  resp_ack;
    logic [2:0]  resp_stall;
    logic [2:0]  resp_err;

    logic [31:0] rd_data;
    logic [15:0] switches;
    logic [15:0] leds;
    logic        sys_int;

    int error_count;
    int tests_run;
    int tests_failed;

    `include "tb_bus_tasks.svh"

    tl45_bus_top dut0 (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_dport_cyc   (req_cyc[0]),
        .i_dport_stb   (req_stb[0]),
        .i_dport_we    (req_we[0]),
        .i_dport_addr  (req_addr[0]),
        .i_dport_data  (req_data[0]),
        .i_dport_sel   (req_sel[0]),
        .o_dport_ack   (resp_ack[0]),
        .o_dport_stall (resp_stall[0]),
        .o_dport_err   (resp_err[0]),
        .i_iport_cyc   (req_cyc[1]),
        .i_iport_stb   (req_stb[1]),
        .i_iport_we    (req_we[1]),
        .i_iport_addr  (req_addr[1]),
        .i_iport_data  (req_data[1]),
        .i_iport_sel   (req_sel[1]),
        .o_iport_ack   (resp_ack[1]),
        .o_iport_stall (resp_stall[1]),
        .o_iport_err   (resp_err[1]),
        .i_dbg_cyc     (req_cyc[2]),
        .i_dbg_stb     (req_stb[2]),
        .i_dbg_we      (req_we[2]),
        .i_dbg_addr    (req_addr[2]),
        .i_dbg_data    (req_data[2]),
        .i_dbg_sel     (req_sel[2]),
        .o_dbg_ack     (resp_ack[2]),
        .o_dbg_stall   (resp_stall[2]),
        .o_dbg_err     (resp_err[2]),
        .o_rd_data     (rd_data),
        .i_switches    (switches),
        .o_leds        (leds),
        .o_sys_int     (sys_int)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TEST_COUNT * TEST_CYCLES) * MARGIN);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        req_cyc      = '0;
        req_stb      = '0;
        req_we       = '0;
        switches     = '0;
        for (int p = 0; p < 3; p++) begin
            req_addr[p] = '0;
            req_data[p] = '0;
            req_sel[p]  = '0;
        end
        // count rising edges under reset, then release on a falling edge
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_and_memory();
        test_sys_device();
        test_bus_error();
        test_switch_led();
        test_arbitration();

        $display("summary: %0d tests run, %0d failed, %0d errors",
            tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/tl45_bus_top.sv */
`timescale 1ns/1ps

module tl45_bus_top
    import tl45_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,

    // data port
    input  logic              i_dport_cyc,
    input  logic              i_dport_stb,
    input  logic              i_dport_we,
    input  logic [ADDR_W-1:0] i_dport_addr,
    input  logic [DATA_W-1:0] i_dport_data,
    input  logic [SEL_W-1:0]  i_dport_sel,
    output logic              o_dport_ack,
    output logic              o_dport_stall,
    output logic              o_dport_err,

    // instruction fetch port
    input  logic              i_iport_cyc,
    input  logic              i_iport_stb,
    input  logic              i_iport_we,
    input  logic [ADDR_W-1:0] i_iport_addr,
    input  logic [DATA_W-1:0] i_iport_data,
    input  logic [SEL_W-1:0]  i_iport_sel,
    output logic              o_iport_ack,
    output logic              o_iport_stall,
    output logic              o_iport_err,

    // debug port
    input  logic              i_dbg_cyc,
    input  logic              i_dbg_stb,
    input  logic              i_dbg_we,
    input  logic [ADDR_W-1:0] i_dbg_addr,
    input  logic [DATA_W-1:0] i_dbg_data,
    input  logic [SEL_W-1:0]  i_dbg_sel,
    output logic              o_dbg_ack,
    output logic              o_dbg_stall,
    output logic              o_dbg_err,

    // read data shared by all requesters
    output logic [DATA_W-1:0] o_rd_data,
    input  logic [LED_W-1:0]  i_switches,
    output logic [LED_W-1:0]  o_leds,
    output logic              o_sys_int
);

    // merged data and fetch bus
    logic              ibus_cyc;
    logic              ibus_stb;
    logic              ibus_we;
    logic [ADDR_W-1:0] ibus_addr;
    logic [DATA_W-1:0] ibus_data;
    logic [SEL_W-1:0]  ibus_sel;
    logic              ibus_ack;
    logic              ibus_stall;
    logic              ibus_err;

    // master bus into the decoder
    logic              mbus_stb;
    logic              mbus_we;
    logic [ADDR_W-1:0] mbus_addr;
    logic [DATA_W-1:0] mbus_data;
    logic [SEL_W-1:0]  mbus_sel;
    logic              mbus_ack;
    logic              mbus_stall;
    logic              mbus_err;

    logic              mem_stb;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_data;
    logic              sys_stb;
    logic              sys_ack;
    logic [DATA_W-1:0] sys_data;
    logic              swled_stb;
    logic              swled_ack;
    logic [DATA_W-1:0] swled_data;

    wb_pri_arbiter inner_arb (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_a_cyc   (i_dport_cyc),
        .i_a_stb   (i_dport_stb),
        .i_a_we    (i_dport_we),
        .i_a_addr  (i_dport_addr),
        .i_a_data  (i_dport_data),
        .i_a_sel   (i_dport_sel),
        .o_a_ack   (o_dport_ack),
        .o_a_stall (o_dport_stall),
        .o_a_err   (o_dport_err),
        .i_b_cyc   (i_iport_cyc),
        .i_b_stb   (i_iport_stb),
        .i_b_we    (i_iport_we),
        .i_b_addr  (i_iport_addr),
        .i_b_data  (i_iport_data),
        .i_b_sel   (i_iport_sel),
        .o_b_ack   (o_iport_ack),
        .o_b_stall (o_iport_stall),
        .o_b_err   (o_iport_err),
        .o_cyc     (ibus_cyc),
        .o_stb     (ibus_stb),
        .o_we      (ibus_we),
        .o_addr    (ibus_addr),
        .o_data    (ibus_data),
        .o_sel     (ibus_sel),
        .i_ack     (ibus_ack),
        .i_stall   (ibus_stall),
        .i_err     (ibus_err)
    );

    // devices look at stb alone, so the master cyc stays open
    wb_pri_arbiter outer_arb (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_a_cyc   (ibus_cyc),
        .i_a_stb   (ibus_stb),
        .i_a_we    (ibus_we),
        .i_a_addr  (ibus_addr),
        .i_a_data  (ibus_data),
        .i_a_sel   (ibus_sel),
        .o_a_ack   (ibus_ack),
        .o_a_stall (ibus_stall),
        .o_a_err   (ibus_err),
        .i_b_cyc   (i_dbg_cyc),
        .i_b_stb   (i_dbg_stb),
        .i_b_we    (i_dbg_we),
        .i_b_addr  (i_dbg_addr),
        .i_b_data  (i_dbg_data),
        .i_b_sel   (i_dbg_sel),
        .o_b_ack   (o_dbg_ack),
        .o_b_stall (o_dbg_stall),
        .o_b_err   (o_dbg_err),
        .o_cyc     (),
        .o_stb     (mbus_stb),
        .o_we      (mbus_we),
        .o_addr    (mbus_addr),
        .o_data    (mbus_data),
        .o_sel     (mbus_sel),
        .i_ack     (mbus_ack),
        .i_stall   (mbus_stall),
        .i_err     (mbus_err)
    );

    bus_decoder decoder0 (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_stb        (mbus_stb),
        .i_addr       (mbus_addr),
        .o_mem_stb    (mem_stb),
        .o_sys_stb    (sys_stb),
        .o_swled_stb  (swled_stb),
        .i_mem_ack    (mem_ack),
        .i_mem_data   (mem_data),
        .i_sys_ack    (sys_ack),
        .i_sys_data   (sys_data),
        .i_swled_ack  (swled_ack),
        .i_swled_data (swled_data),
        .o_ack        (mbus_ack),
        .o_err        (mbus_err),
        .o_stall      (mbus_stall),
        .o_data       (o_rd_data)
    );

    sys_info_dev sys0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_stb       (sys_stb),
        .i_we        (mbus_we),
        .i_addr      (mbus_addr[SYS_REG_AW-1:0]),
        .i_data      (mbus_data),
        .i_bus_err   (mbus_err),
        .i_err_addr  (mbus_addr),
        .o_ack       (sys_ack),
        .o_data      (sys_data),
        .o_interrupt (o_sys_int)
    );

    word_mem mem0 (
        .i_clk  (i_clk),
        .i_stb  (mem_stb),
        .i_we   (mbus_we),
        .i_addr (mbus_addr[MEM_AW-1:0]),
        .i_data (mbus_data),
        .i_sel  (mbus_sel),
        .o_ack  (mem_ack),
        .o_data (mem_data)
    );

    switch_led_dev swled0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_stb      (swled_stb),
        .i_we       (mbus_we),
        .i_data     (mbus_data[LED_W-1:0]),
        .i_sel      (mbus_sel[LED_W/8-1:0]),
        .i_switches (i_switches),
        .o_leds     (o_leds),
        .o_ack      (swled_ack),
        .o_data     (swled_data)
    );

endmodule

/* rtl/switch_led_dev.sv */
`timescale 1ns/1ps

module switch_led_dev
    import tl45_bus_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_stb,
    input  logic                 i_we,
    input  logic [LED_W-1:0]     i_data,
    input  logic [LED_W/8-1:0]   i_sel,
    input  logic [LED_W-1:0]     i_switches,
    output logic [LED_W-1:0]     o_leds,
    output logic                 o_ack,
    output logic [DATA_W-1:0]    o_data
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack  <= 1'b0;
            o_leds <= '0;
        end else begin
            o_ack <= i_stb;
            // leds only change on a full halfword write
            if (i_stb && i_we && (&i_sel)) begin
                o_leds <= i_data;
            end
        end
    end

    // leds in the upper half, switches below
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= {o_leds, i_switches};
        end
    end

endmodule

/* rtl/word_mem.sv */
`timescale 1ns/1ps

module word_mem
    import tl45_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_stb,
    input  logic              i_we,
    input  logic [MEM_AW-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  logic [SEL_W-1:0]  i_sel,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_data
);

    logic [DATA_W-1:0] mem [2**MEM_AW];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (i_sel[b]) begin
                    mem[i_addr][8*b +: 8] <= i_data[8*b +: 8];
                end
            end
        end
    end

    // read word returned with the ack
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= mem[i_addr];
        end
    end

    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule

/* rtl/sys_info_dev.sv */
`timescale 1ns/1ps

module sys_info_dev
    import tl45_bus_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_stb,
    input  logic                  i_we,
    input  logic [SYS_REG_AW-1:0] i_addr,
    input  logic [DATA_W-1:0]     i_data,
    input  logic                  i_bus_err,
    input  logic [ADDR_W-1:0]     i_err_addr,
    output logic                  o_ack,
    output logic [DATA_W-1:0]     o_data,
    output logic                  o_interrupt
);

    logic [DATA_W-1:0] scratch;
    logic [DATA_W-1:0] power_count;
    logic [ADDR_W-1:0] issue_addr;
    logic [ADDR_W-1:0] buserr_addr;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack       <= 1'b0;
            o_interrupt <= 1'b0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we && (i_addr == SYS_REG_INT)) begin
                o_interrupt <= i_data[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb && i_we && (i_addr == SYS_REG_SCRATCH)) begin
            scratch <= i_data;
        end
    end

    // the error flag lags the strobe by a cycle, so keep the address one cycle too
    always_ff @(posedge i_clk) begin
        issue_addr <= i_err_addr;
        if (i_reset) begin
            buserr_addr <= '0;
        end else if (i_bus_err) begin
            buserr_addr <= issue_addr;
        end
    end

    // top bit sticks once reached, low bits keep running
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            power_count <= '0;
        end else if (!power_count[DATA_W-1]) begin
            power_count <= power_count + 1'b1;
        end else begin
            power_count[DATA_W-2:0] <= power_count[DATA_W-2:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (i_addr)
                SYS_REG_ID:      o_data <= SYS_ID_VALUE;
                SYS_REG_SCRATCH: o_data <= scratch;
                SYS_REG_BUSERR:  o_data <= {buserr_addr, 2'b00};
                SYS_REG_POWER:   o_data <= power_count;
                SYS_REG_INT:     o_data <= {{(DATA_W-1){1'b0}}, o_interrupt};
                default:         o_data <= '0;
            endcase
        end
    end

endmodule

/* rtl/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
    import tl45_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,

    input  logic              i_stb,
    input  logic [ADDR_W-1:0] i_addr,

    // per device strobes
    output logic              o_mem_stb,
    output logic              o_sys_stb,
    output logic              o_swled_stb,

    // device responses
    input  logic              i_mem_ack,
    input  logic [DATA_W-1:0] i_mem_data,
    input  logic              i_sys_ack,
    input  logic [DATA_W-1:0] i_sys_data,
    input  logic              i_swled_ack,
    input  logic [DATA_W-1:0] i_swled_data,

    // merged response toward the requesters
    output logic              o_ack,
    output logic              o_err,
    output logic              o_stall,
    output logic [DATA_W-1:0] o_data
);

    logic mem_sel;
    logic sys_sel;
    logic swled_sel;
    logic none_sel;

    logic mem_stall;
    logic sys_stall;
    logic swled_stall;

    // memory and system device each get a whole region
    assign mem_sel   = (i_addr[MAP_REGION_MSB:MAP_REGION_LSB] == MEM_REGION);
    assign sys_sel   = (i_addr[MAP_REGION_MSB:MAP_REGION_LSB] == SYS_REGION);
    assign swled_sel = (i_addr == SWLED_ADDR);
    assign none_sel  = !mem_sel && !sys_sel && !swled_sel;

    assign o_mem_stb   = i_stb && mem_sel;
    assign o_sys_stb   = i_stb && sys_sel;
    assign o_swled_stb = i_stb && swled_sel;

    // none of the on-chip devices hold off a request
    assign mem_stall   = 1'b0;
    assign sys_stall   = 1'b0;
    assign swled_stall = 1'b0;

    assign o_stall = (mem_sel && mem_stall)
                  || (sys_sel && sys_stall)
                  || (swled_sel && swled_stall);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_err <= 1'b0;
            o_ack <= 1'b0;
        end else begin
            // unmapped strobe answers on the very next cycle
            o_err <= i_stb && none_sel;
            o_ack <= i_mem_ack || i_sys_ack || i_swled_ack;
        end
    end

    // read data of whichever device acked, zero when idle
    always_ff @(posedge i_clk) begin
        if (i_sys_ack) begin
            o_data <= i_sys_data;
        end else if (i_mem_ack) begin
            o_data <= i_mem_data;
        end else if (i_swled_ack) begin
            o_data <= i_swled_data;
        end else begin
            o_data <= '0;
        end
    end

endmodule

/* rtl/wb_pri_arbiter.sv */
`timescale 1ns/1ps

module wb_pri_arbiter
    import tl45_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,

    // port a, the high priority requester
    input  logic              i_a_cyc,
    input  logic              i_a_stb,
    input  logic              i_a_we,
    input  logic [ADDR_W-1:0] i_a_addr,
    input  logic [DATA_W-1:0] i_a_data,
    input  logic [SEL_W-1:0]  i_a_sel,
    output logic              o_a_ack,
    output logic              o_a_stall,
    output logic              o_a_err,

    // port b
    input  logic              i_b_cyc,
    input  logic              i_b_stb,
    input  logic              i_b_we,
    input  logic [ADDR_W-1:0] i_b_addr,
    input  logic [DATA_W-1:0] i_b_data,
    input  logic [SEL_W-1:0]  i_b_sel,
    output logic              o_b_ack,
    output logic              o_b_stall,
    output logic              o_b_err,

    // shared downstream bus
    output logic              o_cyc,
    output logic              o_stb,
    output logic              o_we,
    output logic [ADDR_W-1:0] o_addr,
    output logic [DATA_W-1:0] o_data,
    output logic [SEL_W-1:0]  o_sel,
    input  logic              i_ack,
    input  logic              i_stall,
    input  logic              i_err
);

    // 0 means port a owns the bus
    logic owner_b;
    logic owner_cyc;

    assign owner_cyc = owner_b ? i_b_cyc : i_a_cyc;

    // ownership only moves once the current owner has left the bus
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner_b <= 1'b0;
        end else if (!owner_cyc) begin
            owner_b <= !i_a_cyc && i_b_cyc;
        end
    end

    assign o_cyc  = owner_cyc;
    assign o_stb  = owner_b ? (i_b_cyc && i_b_stb) : (i_a_cyc && i_a_stb);
    assign o_we   = owner_b ? i_b_we   : i_a_we;
    assign o_addr = owner_b ? i_b_addr : i_a_addr;
    assign o_data = owner_b ? i_b_data : i_a_data;
    assign o_sel  = owner_b ? i_b_sel  : i_a_sel;

    // responses reach the owner only, the other side waits under stall
    assign o_a_ack   = !owner_b && i_ack;
    assign o_a_err   = !owner_b && i_err;
    assign o_a_stall = owner_b || i_stall;

    assign o_b_ack   = owner_b && i_ack;
    assign o_b_err   = owner_b && i_err;
    assign o_b_stall = !owner_b || i_stall;

endmodule

/* rtl/tl45_bus_pkg.sv */
package tl45_bus_pkg;

    // bus geometry
    localparam int DATA_W = 32;
    localparam int ADDR_W = 30;
    localparam int SEL_W  = DATA_W / 8;

    // word address bits decoded by the on-chip memory
    localparam int MEM_AW = 14;

    // large regions of the word address space
    localparam int MAP_REGION_MSB = 29;
    localparam int MAP_REGION_LSB = 21;

    localparam logic [MAP_REGION_MSB-MAP_REGION_LSB:0] MEM_REGION = 9'h000;
    localparam logic [MAP_REGION_MSB-MAP_REGION_LSB:0] SYS_REGION = 9'h001;

    // single word device in region 2
    localparam logic [ADDR_W-1:0] SWLED_ADDR = 30'h0040_0001;

    // system device register file
    localparam logic [DATA_W-1:0] SYS_ID_VALUE = 32'h2019_1028;

    localparam int SYS_REG_AW = 4;

    localparam logic [SYS_REG_AW-1:0] SYS_REG_ID      = 4'h0;
    localparam logic [SYS_REG_AW-1:0] SYS_REG_SCRATCH = 4'h1;
    localparam logic [SYS_REG_AW-1:0] SYS_REG_BUSERR  = 4'h2;
    localparam logic [SYS_REG_AW-1:0] SYS_REG_POWER   = 4'h3;
    localparam logic [SYS_REG_AW-1:0] SYS_REG_INT     = 4'h4;

    // switch and led fields share one read word
    localparam int LED_W = 16;

endpackage
